//--- source/onewire_pkg.sv
`default_nettype none

package onewire_pkg;

   localparam int unsigned clock_rate_hz = 10_000_000;
   localparam int unsigned cycles_per_usec = clock_rate_hz / 1_000_000;
   localparam int unsigned prescale_width = $clog2(cycles_per_usec);

   // slot timing in microseconds
   localparam int unsigned reset_low_us = 480;
   localparam int unsigned reset_listen_us = 480;
   localparam int unsigned presence_from_us = 60;
   localparam int unsigned slot_us = 60;
   localparam int unsigned init_low_us = 1;
   localparam int unsigned read_sample_us = 12;   // counted from release
   localparam int unsigned recovery_us = 4;

   localparam int unsigned usec_width = $clog2(reset_low_us + 1);

   localparam int unsigned data_width = 18;
   localparam int unsigned addr_width = 4;
   localparam logic [addr_width-1:0] reg_control = addr_width'(0);
   localparam logic [addr_width-1:0] reg_data = addr_width'(1);

   typedef enum logic [1:0] {
      op_reset,
      op_write0,
      op_write1,
      op_read
   } onewire_op_e;

   typedef enum logic [2:0] {
      st_idle,
      st_init_low,
      st_listen,
      st_slot_release,
      st_recovery
   } seq_state_e;

   typedef struct packed {
      logic start;
      onewire_op_e op;
   } onewire_cmd_t;

   typedef struct packed {
      logic busy;
      logic presence;
      logic data_bit;
      logic done;
   } onewire_status_t;

   typedef struct packed {
      logic low_enable;
      logic source;   // owner of the pin wants it
   } onewire_drive_t;

endpackage

`default_nettype wire

//--- source/onewire_line.sv
`default_nettype none

module onewire_line (
   input  logic                       clock,
   input  logic                       clock_sreset,
   input  onewire_pkg::onewire_drive_t seq_drive,
   input  onewire_pkg::onewire_drive_t host_drive,
   input  logic                       busy,
   output logic                       line_level,
   inout  wire logic                  onewire
);

   logic       seq_low;
   logic       host_low;
   logic       pin_low;
   logic [2:0] sync;

   assign seq_low = seq_drive.source & seq_drive.low_enable;
   assign host_low = ~busy & host_drive.source & host_drive.low_enable;   // masked during a slot

   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         pin_low <= 1'b0;
         sync <= 3'b111;   // idle bus reads high
      end
      else begin
         pin_low <= seq_low | host_low;
         sync <= {sync[1:0], onewire};
      end
   end

   assign line_level = sync[2];

   // open drain, pull-up restores the high level
   assign onewire = pin_low ? 1'b0 : 1'bz;

endmodule

`default_nettype wire

//--- source/onewire_timer.sv
`default_nettype none

module onewire_timer (
   input  logic                                clock,
   input  logic                                clock_sreset,
   input  logic                                restart,
   output logic                                usec_tick,
   output logic [onewire_pkg::usec_width-1:0]  usec_count
);

   import onewire_pkg::*;

   logic [prescale_width-1:0] prescale;
   logic                      usec_edge;
   logic                      prescale_wrap;

   // tick is registered, so it is flagged one count early
   assign usec_edge = (prescale == prescale_width'(cycles_per_usec - 2));
   assign prescale_wrap = (prescale == prescale_width'(cycles_per_usec - 1));

   always_ff @(posedge clock) begin
      if (clock_sreset || restart) begin
         prescale <= '0;
         usec_tick <= 1'b0;
         usec_count <= '0;
      end
      else begin
         usec_tick <= usec_edge;
         if (prescale_wrap) begin
            prescale <= '0;
         end
         else begin
            prescale <= prescale + 1'b1;
         end
         if (usec_edge) begin
            usec_count <= usec_count + 1'b1;   // valid together with the tick
         end
      end
   end

endmodule

`default_nettype wire

//--- source/onewire_sequencer.sv
`default_nettype none

module onewire_sequencer (
   input  logic                                clock,
   input  logic                                clock_sreset,
   input  onewire_pkg::onewire_cmd_t           cmd,
   input  logic                                line_level,
   input  logic                                usec_tick,
   input  logic [onewire_pkg::usec_width-1:0]  usec_count,
   output logic                                restart,
   output onewire_pkg::onewire_drive_t         drive,
   output onewire_pkg::onewire_status_t        status
);

   import onewire_pkg::*;

   seq_state_e            state;
   seq_state_e            state_next;
   onewire_op_e           op_reg;
   logic [usec_width-1:0] phase_us;
   logic                  phase_end;
   logic                  presence_reg;
   logic                  data_bit_reg;

   always_comb begin
      case (state)
         st_init_low : begin
            case (op_reg)
               op_reset  : phase_us = usec_width'(reset_low_us);
               op_write0 : phase_us = usec_width'(slot_us);
               default   : phase_us = usec_width'(init_low_us);
            endcase
         end
         st_listen       : phase_us = usec_width'(reset_listen_us);
         st_slot_release : phase_us = usec_width'(slot_us - init_low_us);   // rest of the slot
         default         : phase_us = usec_width'(recovery_us);
      endcase
   end

   assign phase_end = usec_tick && (usec_count == phase_us) && (state != st_idle);

   always_comb begin
      state_next = state;
      case (state)
         st_idle : begin
            if (cmd.start) begin
               state_next = st_init_low;
            end
         end
         st_init_low : begin
            if (phase_end) begin
               case (op_reg)
                  op_reset  : state_next = st_listen;
                  op_write0 : state_next = st_recovery;
                  default   : state_next = st_slot_release;
               endcase
            end
         end
         st_listen, st_slot_release : begin
            if (phase_end) begin
               state_next = st_recovery;
            end
         end
         st_recovery : begin
            if (phase_end) begin
               state_next = st_idle;
            end
         end
         default : state_next = st_idle;
      endcase
   end

   // timer held at zero while idle, restarted at each phase boundary
   assign restart = (state == st_idle) || phase_end;

   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         state <= st_idle;
         presence_reg <= 1'b0;
         data_bit_reg <= 1'b0;
      end
      else begin
         state <= state_next;
         if ((state == st_idle) && (cmd.op == op_reset) && cmd.start) begin
            presence_reg <= 1'b0;
         end
         if ((state == st_listen) && usec_tick && !line_level &&
             (usec_count >= usec_width'(presence_from_us))) begin
            presence_reg <= 1'b1;   // device answered
         end
         if ((state == st_slot_release) && (op_reg == op_read) && usec_tick &&
             (usec_count == usec_width'(read_sample_us))) begin
            data_bit_reg <= line_level;
         end
      end
   end

   always_ff @(posedge clock) begin
      if ((state == st_idle) && cmd.start) begin
         op_reg <= cmd.op;
      end
   end

   assign drive.low_enable = (state == st_init_low);
   assign drive.source = (state != st_idle);

   assign status.busy = (state != st_idle);
   assign status.presence = presence_reg;
   assign status.data_bit = data_bit_reg;
   assign status.done = (state == st_recovery) && phase_end;   // last busy cycle

endmodule

`default_nettype wire

//--- source/onewire_host_regs.sv
`default_nettype none

module onewire_host_regs (
   input  logic                                clock,
   input  logic                                clock_sreset,
   input  logic [onewire_pkg::addr_width-1:0]  address,
   input  logic [onewire_pkg::data_width-1:0]  writedata,
   input  logic                                read,
   input  logic                                write,
   output logic [onewire_pkg::data_width-1:0]  readdata,
   output logic                                waitrequest,
   output logic                                irq,
   input  onewire_pkg::onewire_status_t        status,
   input  logic                                line_level,
   output onewire_pkg::onewire_cmd_t           cmd,
   output onewire_pkg::onewire_drive_t         host_drive
);

   import onewire_pkg::*;

   logic                  read_latency;
   logic                  status_read_done;
   logic                  manual_write;
   logic [data_width-1:0] read_mux;
   onewire_drive_t        manual_drive;

   // writes never stall, reads wait one cycle
   assign waitrequest = write ? 1'b0 : (read & ~read_latency);

   assign cmd.start = write && (address == reg_control) && !status.busy;
   assign cmd.op = onewire_op_e'(writedata[1:0]);

   assign manual_write = write && (address == reg_data) && !status.busy;
   assign status_read_done = read && read_latency && (address == reg_control);

   always_comb begin
      case (address)
         reg_control : read_mux = {{(data_width-3){1'b0}}, status.presence, status.busy,
                                   line_level};
         reg_data    : read_mux = {{(data_width-1){1'b0}}, status.data_bit};
         default     : read_mux = '0;
      endcase
   end

   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         read_latency <= 1'b0;
         irq <= 1'b0;
         manual_drive <= '0;
      end
      else begin
         read_latency <= read_latency ? 1'b0 : read;
         if (status.done) begin
            irq <= 1'b1;   // a finishing slot wins over the clear
         end
         else if (status_read_done) begin
            irq <= 1'b0;
         end
         if (manual_write) begin
            manual_drive.source <= ~writedata[1];   // bit 1 hands the pin back
            manual_drive.low_enable <= ~writedata[0];
         end
      end
   end

   always_ff @(posedge clock) begin
      if (read && !read_latency) begin
         readdata <= read_mux;
      end
   end

   assign host_drive = manual_drive;

endmodule

`default_nettype wire

//--- source/onewire_master.sv
`default_nettype none

module onewire_master (
   input  logic                                clock,
   input  logic                                clock_sreset,
   input  logic [onewire_pkg::addr_width-1:0]  address,
   input  logic [onewire_pkg::data_width-1:0]  writedata,
   input  logic                                read,
   input  logic                                write,
   output logic [onewire_pkg::data_width-1:0]  readdata,
   output logic                                waitrequest,
   output logic                                irq,
   inout  wire logic                           onewire
);

   import onewire_pkg::*;

   onewire_cmd_t          cmd;
   onewire_status_t       status;
   onewire_drive_t        seq_drive;
   onewire_drive_t        host_drive;
   logic                  line_level;
   logic                  restart;
   logic                  usec_tick;
   logic [usec_width-1:0] usec_count;

   onewire_host_regs i_onewire_host_regs (
      .clock        (clock),
      .clock_sreset (clock_sreset),
      .address      (address),
      .writedata    (writedata),
      .read         (read),
      .write        (write),
      .readdata     (readdata),
      .waitrequest  (waitrequest),
      .irq          (irq),
      .status       (status),
      .line_level   (line_level),
      .cmd          (cmd),
      .host_drive   (host_drive)
   );

   onewire_sequencer i_onewire_sequencer (
      .clock        (clock),
      .clock_sreset (clock_sreset),
      .cmd          (cmd),
      .line_level   (line_level),
      .usec_tick    (usec_tick),
      .usec_count   (usec_count),
      .restart      (restart),
      .drive        (seq_drive),
      .status       (status)
   );

   onewire_timer i_onewire_timer (
      .clock        (clock),
      .clock_sreset (clock_sreset),
      .restart      (restart),
      .usec_tick    (usec_tick),
      .usec_count   (usec_count)
   );

   onewire_line i_onewire_line (
      .clock        (clock),
      .clock_sreset (clock_sreset),
      .seq_drive    (seq_drive),
      .host_drive   (host_drive),
      .busy         (status.busy),   // sequencer owns the pin during a slot
      .line_level   (line_level),
      .onewire      (onewire)
   );

endmodule

`default_nettype wire

//--- verif/onewire_slave_model.sv
`default_nettype none

module onewire_slave_model (
   inout  wire         onewire,
   input  logic        present,
   input  logic        read_value,
   output int          last_width_us,
   output logic [31:0] bit_log,
   output int          pulse_count
);

   timeunit 1ns;
   timeprecision 1ps;

   logic    pull_low = 1'b0;
   realtime fall_time;

   assign onewire = pull_low ? 1'b0 : 1'bz;

   initial begin
      last_width_us = 0;
      bit_log = '0;
      pulse_count = 0;
      forever begin
         @(negedge onewire);
         fall_time = $realtime;
         @(posedge onewire);
         last_width_us = int'(($realtime - fall_time) / 1000.0);   // nearest whole us
         pulse_count++;
         if (last_width_us >= 400) begin
            if (present) begin
               #30us;
               pull_low = 1'b1;   // presence pulse
               #120us;
               pull_low = 1'b0;
            end
         end
         else if (last_width_us < 15) begin
            bit_log = {bit_log[30:0], 1'b1};
            if (!read_value) begin
               pull_low = 1'b1;   // stretch the slot to answer a zero
               #(fall_time + 40us - $realtime);
               pull_low = 1'b0;
            end
         end
         else begin
            bit_log = {bit_log[30:0], 1'b0};
         end
      end
   end

endmodule

`default_nettype wire

//--- verif/onewire_master_assertions.sv
`default_nettype none

module onewire_master_assertions (
   input logic                          clock,
   input logic                          clock_sreset,
   input onewire_pkg::seq_state_e       state,
   input onewire_pkg::onewire_op_e      op_reg,
   input onewire_pkg::onewire_cmd_t     cmd,
   input onewire_pkg::onewire_drive_t   drive,
   input onewire_pkg::onewire_status_t  status,
   input logic                          line_level
);

   timeunit 1ns;
   timeprecision 1ps;

   import onewire_pkg::*;

   int failures = 0;

   done_then_idle : assert property (@(posedge clock) disable iff (clock_sreset)
      status.done |=> (state == st_idle))
      else begin
         $error("sequencer not idle after done");
         failures++;
      end

   // pin release plus synchronizer delay, then the line must read high
   recovery_released : assert property (@(posedge clock) disable iff (clock_sreset)
      ((state == st_recovery) && $past(state == st_recovery, 4)) |-> line_level)
      else begin
         $error("line pulled low during recovery");
         failures++;
      end

   // a command written during a slot must not reach the sequencer
   start_ignored_busy : assert property (@(posedge clock) disable iff (clock_sreset)
      status.busy |-> !cmd.start)
      else begin
         $error("command accepted while busy");
         failures++;
      end

endmodule

bind onewire_sequencer onewire_master_assertions i_onewire_master_assertions (.*);

`default_nettype wire

//--- verif/onewire_master_tb.sv
`default_nettype none

module onewire_master_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import onewire_pkg::*;

   localparam int irq_timeout = 20000;   // cycles, a reset slot is under 10000

   logic                  clock = 1'b0;
   logic                  clock_sreset;
   logic [addr_width-1:0] address;
   logic [data_width-1:0] writedata;
   logic                  read;
   logic                  write;
   logic [data_width-1:0] readdata;
   logic                  waitrequest;
   logic                  irq;
   wire                   onewire;
   logic                  present;
   logic                  read_value;
   int                    last_width_us;
   logic [31:0]           bit_log;
   int                    pulse_count;
   logic [31:0]           seed = 32'h2e49;
   int                    errors = 0;
   int                    checks = 0;

   pullup (onewire);

   always #50 clock = ~clock;

   onewire_master i_onewire_master (.*);

   onewire_slave_model i_onewire_slave_model (.*);

   function automatic logic rand_bit();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed[16];
   endfunction

   task automatic check_equal(input string what, input int got, input int expected);
      checks++;
      assert (got == expected) else begin
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int mark);
      $display("test %s: %0d errors", name, errors - mark);
   endtask

   task automatic bus_write(input logic [addr_width-1:0] addr, input int data);
      @(posedge clock);
      address <= addr;
      writedata <= data_width'(data);
      write <= 1'b1;
      @(negedge clock);
      check_equal("write waitrequest", waitrequest, 0);
      @(posedge clock);
      write <= 1'b0;
   endtask

   task automatic bus_read(input logic [addr_width-1:0] addr,
                           output logic [data_width-1:0] data);
      int waits;
      int cycles;
      waits = 0;
      cycles = 0;
      @(posedge clock);
      address <= addr;
      read <= 1'b1;
      do begin
         @(negedge clock);
         cycles++;
         if (waitrequest) begin
            waits++;
         end
      end while (waitrequest && cycles < 8);
      if (waitrequest) begin
         $display("timeout: read at address %0d never completed", addr);
         errors++;
      end
      data = readdata;
      check_equal("read wait cycles", waits, 1);
      @(posedge clock);
      read <= 1'b0;
   endtask

   task automatic wait_irq();
      int cycles;
      cycles = 0;
      while (!irq && cycles < irq_timeout) begin
         @(negedge clock);
         cycles++;
      end
      if (!irq) begin
         $display("timeout: irq did not rise within %0d cycles", irq_timeout);
         errors++;
      end
   endtask

   task automatic run_slot(input onewire_op_e op, output logic [data_width-1:0] status_word);
      bus_write(reg_control, op);
      wait_irq();
      bus_read(reg_control, status_word);   // clears irq too
   endtask

   initial begin
      logic [data_width-1:0] rdata;
      logic [7:0]            sent;
      logic                  value;
      logic [1:0]            code;
      onewire_op_e           op;
      int                    mark;
      int                    count_before;
      clock_sreset = 1'b1;
      address = '0;
      writedata = '0;
      read = 1'b0;
      write = 1'b0;
      present = 1'b0;
      read_value = 1'b1;
      repeat (2) @(posedge clock);
      clock_sreset <= 1'b0;

      for (int p = 1; p >= 0; p--) begin
         mark = errors;
         present <= p[0];
         run_slot(op_reset, rdata);
         check_equal("presence", rdata[2], p);
         checks++;
         assert (last_width_us >= 479 && last_width_us <= 481) else begin
            $display("** Error at %0t ns: reset pulse is %0d us", $time, last_width_us);
            errors++;
         end
         report_test(p ? "reset, device present" : "reset, device absent", mark);
      end

      mark = errors;
      sent = '0;
      for (int i = 0; i < 8; i++) begin
         value = rand_bit();
         sent = {sent[6:0], value};
         run_slot(value ? op_write1 : op_write0, rdata);
         check_equal("write slot low width", last_width_us, value ? init_low_us : slot_us);
      end
      check_equal("device bit log", bit_log[7:0], sent);
      report_test("write slots", mark);

      mark = errors;
      for (int i = 0; i < 8; i++) begin
         value = rand_bit();
         read_value <= value;
         run_slot(op_read, rdata);
         bus_read(reg_data, rdata);
         check_equal("read bit", rdata[0], value);
      end
      read_value <= 1'b1;
      report_test("read slots", mark);

      mark = errors;
      op = rand_bit() ? op_write1 : op_write0;
      count_before = pulse_count;
      bus_write(reg_control, op);
      bus_read(reg_control, rdata);
      check_equal("busy after issue", rdata[1], 1);
      check_equal("irq during slot", irq, 0);
      bus_write(reg_control, op_reset);   // dropped, slot in flight
      wait_irq();
      bus_read(reg_control, rdata);
      check_equal("busy at irq", rdata[1], 0);
      @(negedge clock);
      check_equal("irq after status read", irq, 0);
      check_equal("slots on the bus", pulse_count - count_before, 1);
      check_equal("slot low width", last_width_us, op == op_write1 ? init_low_us : slot_us);
      report_test("busy and irq", mark);

      mark = errors;
      for (int i = 0; i < 6; i++) begin
         if (i % 2 == 0) begin
            code = 2'b00;   // pull low
         end
         else begin
            code[1] = rand_bit();
            code[0] = ~code[1] | rand_bit();   // any release pattern
         end
         bus_write(reg_data, code);
         for (int tries = 0; tries < 8; tries++) begin
            bus_read(reg_control, rdata);
            if (rdata[0] == (code[1] | code[0])) begin
               break;
            end
         end
         check_equal("line level under manual drive", rdata[0], code[1] | code[0]);
      end
      bus_write(reg_data, 2);
      report_test("manual drive", mark);

      check_equal("bound assertion failures",
                  i_onewire_master.i_onewire_sequencer.i_onewire_master_assertions.failures, 0);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end
      else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- onewire_master.f
source/onewire_pkg.sv
source/onewire_line.sv
source/onewire_timer.sv
source/onewire_sequencer.sv
source/onewire_host_regs.sv
source/onewire_master.sv
verif/onewire_slave_model.sv
verif/onewire_master_assertions.sv
verif/onewire_master_tb.sv
